// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_mem_stage
FILELIST  ?= rv_mem_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rv_mem_stage.f ====
src/rv_mem_pkg.sv
src/mem_ctrl_fsm.sv
src/mem_wait_timer.sv
src/mem_stage_regs.sv
src/store_align.sv
src/data_ram.sv
src/load_result.sv
src/rv_mem_stage.sv
tb/mem_stage_checker.sv
tb/tb_rv_mem_stage.sv

// ==== src/data_ram.sv ====
// little-endian word RAM; contents are not reset, read data only changes on enabled reads
`timescale 1ns/1ps

module data_ram (
  input  logic                                 i_clk,
  input  logic                                 i_en,
  input  logic                                 i_wen,
  input  logic [rv_mem_pkg::BYTE_EN_WD-1:0]    i_byte_en,
  input  logic [rv_mem_pkg::MEM_DEPTH_LOG2-1:0] i_addr,
  input  logic [rv_mem_pkg::WORD_WD-1:0]       i_wdata,
  output logic [rv_mem_pkg::WORD_WD-1:0]       o_rdata
);

  import rv_mem_pkg::*;

  logic [WORD_WD-1:0] mem [MEM_DEPTH];

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      if (i_wen) begin
        for (int b = 0; b < BYTE_EN_WD; b++) begin
          if (i_byte_en[b]) begin
            mem[i_addr][8*b +: 8] <= i_wdata[8*b +: 8];
          end
        end
      end else begin
        o_rdata <= mem[i_addr];
      end
    end
  end

endmodule

// ==== src/load_result.sv ====
// aligned loads only; result priority is load data, then CSR read data, then ALU result
`timescale 1ns/1ps

module load_result (
  input  logic [1:0]                     i_addr_lo,
  input  rv_mem_pkg::mem_op_e            i_mem_op,
  input  logic                           i_mem_ren,
  input  logic                           i_csr_inst_sel,
  input  logic [rv_mem_pkg::WORD_WD-1:0] i_load_word,
  input  logic [rv_mem_pkg::WORD_WD-1:0] i_csrrdata,
  input  logic [rv_mem_pkg::WORD_WD-1:0] i_alu_result,
  output logic [rv_mem_pkg::WORD_WD-1:0] o_gpr_result
);

  import rv_mem_pkg::*;

  logic [7:0]         lane_b;
  logic [15:0]        lane_h;
  logic [WORD_WD-1:0] load_val;

  assign lane_b = i_load_word[{i_addr_lo, 3'b000} +: 8];
  assign lane_h = i_addr_lo[1] ? i_load_word[31:16] : i_load_word[15:0];

  always_comb begin
    unique case (i_mem_op)
      MEM_B: begin
        load_val = {{24{lane_b[7]}}, lane_b};
      end
      MEM_BU: begin
        load_val = {24'b0, lane_b};
      end
      MEM_H: begin
        load_val = {{16{lane_h[15]}}, lane_h};
      end
      MEM_HU: begin
        load_val = {16'b0, lane_h};
      end
      default: begin
        load_val = i_load_word; // LW
      end
    endcase
  end

  always_comb begin
    if (i_mem_ren) begin
      o_gpr_result = load_val;
    end else if (i_csr_inst_sel) begin
      o_gpr_result = i_csrrdata; // csrr* writes old csr value to rd
    end else begin
      o_gpr_result = i_alu_result;
    end
  end

endmodule

// ==== src/mem_ctrl_fsm.sv ====
// one instruction at a time; strobes seen outside MS_IDLE are dropped, no writeback stall
`timescale 1ns/1ps

module mem_ctrl_fsm (
  input  logic i_clk,
  input  logic i_reset,
  input  logic i_es_valid,
  input  logic i_mem_ren,
  input  logic i_mem_wen,
  input  logic i_timer_done,
  output logic o_accept,
  output logic o_timer_start,
  output logic o_ram_en,
  output logic o_load_capture,
  output logic o_ws_valid,
  output logic o_busy
);

  import rv_mem_pkg::*;

  ms_state_e state_q;
  ms_state_e state_d;
  logic      need_mem;

  assign need_mem = i_mem_ren | i_mem_wen; // raw fields, only looked at on accept

  assign o_accept      = i_es_valid & (state_q == MS_IDLE);
  assign o_timer_start = o_accept & need_mem;

  // last wait cycle, RAM works on the closing edge
  assign o_ram_en       = (state_q == MS_ACCESS) & i_timer_done;
  assign o_load_capture = o_ram_en; // regs qualify with the held read enable

  assign o_ws_valid = (state_q == MS_DONE);
  assign o_busy     = (state_q != MS_IDLE);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      MS_IDLE: begin
        if (o_accept) begin
          state_d = need_mem ? MS_ACCESS : MS_DONE;
        end
      end
      MS_ACCESS: begin
        if (i_timer_done) begin
          state_d = MS_DONE;
        end
      end
      MS_DONE: begin
        state_d = MS_IDLE; // single writeback cycle
      end
      default: begin
        state_d = MS_IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state_q <= MS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== src/mem_stage_regs.sv ====
// fields only change on accept; the load word is forwarded from the RAM in the writeback cycle
`timescale 1ns/1ps

module mem_stage_regs (
  input  logic                               i_clk,
  input  logic                               i_reset,
  input  logic                               i_accept,
  input  logic                               i_load_capture,
  input  logic [rv_mem_pkg::GPR_ADDR_WD-1:0] i_rd,
  input  logic [rv_mem_pkg::CSR_ADDR_WD-1:0] i_csr,
  input  logic                               i_gpr_wen,
  input  logic                               i_csr_wen,
  input  logic                               i_mem_ren,
  input  logic                               i_mem_wen,
  input  rv_mem_pkg::mem_op_e                i_mem_op,
  input  logic                               i_csr_inst_sel,
  input  logic [rv_mem_pkg::WORD_WD-1:0]     i_rs2data,
  input  logic [rv_mem_pkg::WORD_WD-1:0]     i_csrrdata,
  input  logic [rv_mem_pkg::WORD_WD-1:0]     i_alu_result,
  input  logic [rv_mem_pkg::WORD_WD-1:0]     i_csr_result,
  input  logic [rv_mem_pkg::WORD_WD-1:0]     i_ram_rdata,
  output logic [rv_mem_pkg::GPR_ADDR_WD-1:0] o_rd,
  output logic [rv_mem_pkg::CSR_ADDR_WD-1:0] o_csr,
  output logic                               o_gpr_wen,
  output logic                               o_csr_wen,
  output logic                               o_mem_ren,
  output logic                               o_mem_wen,
  output rv_mem_pkg::mem_op_e                o_mem_op,
  output logic                               o_csr_inst_sel,
  output logic [rv_mem_pkg::WORD_WD-1:0]     o_rs2data,
  output logic [rv_mem_pkg::WORD_WD-1:0]     o_csrrdata,
  output logic [rv_mem_pkg::WORD_WD-1:0]     o_alu_result,
  output logic [rv_mem_pkg::WORD_WD-1:0]     o_csr_result,
  output logic [rv_mem_pkg::WORD_WD-1:0]     o_load_word
);

  import rv_mem_pkg::*;

  logic               load_fwd; // RAM output is fresh this cycle
  logic [WORD_WD-1:0] load_word_q;

  assign o_load_word = load_fwd ? i_ram_rdata : load_word_q;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_gpr_wen <= 1'b0;
      o_csr_wen <= 1'b0;
      o_mem_ren <= 1'b0;
      o_mem_wen <= 1'b0;
      load_fwd  <= 1'b0;
    end else begin
      if (i_accept) begin
        o_gpr_wen <= i_gpr_wen;
        o_csr_wen <= i_csr_wen;
        o_mem_ren <= i_mem_ren;
        o_mem_wen <= i_mem_wen;
      end
      load_fwd <= i_load_capture & o_mem_ren;
    end
  end

  // payload
  always_ff @(posedge i_clk) begin
    if (i_accept) begin
      o_rd           <= i_rd;
      o_csr          <= i_csr;
      o_mem_op       <= i_mem_op;
      o_csr_inst_sel <= i_csr_inst_sel;
      o_rs2data      <= i_rs2data;
      o_csrrdata     <= i_csrrdata;
      o_alu_result   <= i_alu_result;
      o_csr_result   <= i_csr_result;
    end
    if (load_fwd) begin
      load_word_q <= i_ram_rdata; // keep after the RAM moves on
    end
  end

endmodule

// ==== src/mem_wait_timer.sv ====
// fixed-length wait of MEM_LATENCY cycles; a start while running restarts the count
`timescale 1ns/1ps

module mem_wait_timer (
  input  logic i_clk,
  input  logic i_reset,
  input  logic i_start,
  output logic o_done
);

  import rv_mem_pkg::*;

  logic                  running;
  logic [LAT_CNT_WD-1:0] count;

  assign o_done = running & (count == '0);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      running <= 1'b0;
      count   <= '0;
    end else if (i_start) begin
      running <= 1'b1;
      count   <= LAT_CNT_WD'(MEM_LATENCY - 1);
    end else if (o_done) begin
      running <= 1'b0; // expired
    end else if (running) begin
      count <= count - 1'b1;
    end
  end

endmodule

// ==== src/rv_mem_pkg.sv ====
// shared sizes and encodings for the memory stage; RAM depth and access latency are fixed here
package rv_mem_pkg;

  // data path and register file widths
  localparam int WORD_WD     = 32;
  localparam int GPR_ADDR_WD = 5;
  localparam int CSR_ADDR_WD = 12;

  // one enable bit per byte lane
  localparam int BYTE_EN_WD  = WORD_WD / 8;

  // 256 words, 1 KiB
  localparam int MEM_DEPTH_LOG2 = 8;
  localparam int MEM_DEPTH      = 2 ** MEM_DEPTH_LOG2;

  // wait cycles of one RAM access, at least 1
  localparam int MEM_LATENCY = 3;

  // wide enough to hold MEM_LATENCY-1
  localparam int LAT_CNT_WD  = $clog2(MEM_LATENCY + 1);

  // load/store size, funct3 encoding
  typedef enum logic [2:0] {
    MEM_B  = 3'd0,
    MEM_H  = 3'd1,
    MEM_W  = 3'd2,
    MEM_BU = 3'd4,
    MEM_HU = 3'd5
  } mem_op_e;

  // control states of the stage
  typedef enum logic [1:0] {
    MS_IDLE   = 2'd0,
    MS_ACCESS = 2'd1,
    MS_DONE   = 2'd2
  } ms_state_e;

endpackage

// ==== src/rv_mem_stage.sv ====
// no pipelining, no misaligned access, no writeback stall; outputs valid only with o_ws_valid
`timescale 1ns/1ps

module rv_mem_stage (
  input  logic                               i_clk,
  input  logic                               i_reset,
  // from execute
  input  logic                               i_es_valid,
  input  logic [rv_mem_pkg::GPR_ADDR_WD-1:0] i_rd,
  input  logic [rv_mem_pkg::CSR_ADDR_WD-1:0] i_csr,
  input  logic                               i_gpr_wen,
  input  logic                               i_csr_wen,
  input  logic                               i_mem_ren,
  input  logic                               i_mem_wen,
  input  rv_mem_pkg::mem_op_e                i_mem_op,
  input  logic                               i_csr_inst_sel,
  input  logic [rv_mem_pkg::WORD_WD-1:0]     i_rs2data,
  input  logic [rv_mem_pkg::WORD_WD-1:0]     i_csrrdata,
  input  logic [rv_mem_pkg::WORD_WD-1:0]     i_alu_result,
  input  logic [rv_mem_pkg::WORD_WD-1:0]     i_csr_result,
  // to writeback
  output logic                               o_ws_valid,
  output logic                               o_gpr_wen,
  output logic [rv_mem_pkg::GPR_ADDR_WD-1:0] o_rd,
  output logic [rv_mem_pkg::WORD_WD-1:0]     o_gpr_result,
  output logic                               o_csr_wen,
  output logic [rv_mem_pkg::CSR_ADDR_WD-1:0] o_csr,
  output logic [rv_mem_pkg::WORD_WD-1:0]     o_csr_result,
  // to execute
  output logic                               o_ms_busy
);

  import rv_mem_pkg::*;

  logic                  accept;
  logic                  timer_start;
  logic                  timer_done;
  logic                  ram_en;
  logic                  load_capture;

  logic                  ms_mem_ren;
  logic                  ms_mem_wen;
  mem_op_e               ms_mem_op;
  logic                  ms_csr_inst_sel;
  logic [WORD_WD-1:0]    ms_rs2data;
  logic [WORD_WD-1:0]    ms_csrrdata;
  logic [WORD_WD-1:0]    ms_alu_result; // x[rs1] + imm, also the RAM address
  logic [WORD_WD-1:0]    load_word;

  logic [BYTE_EN_WD-1:0] ram_byte_en;
  logic [WORD_WD-1:0]    ram_wdata;
  logic [WORD_WD-1:0]    ram_rdata;

  mem_ctrl_fsm u_fsm (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_es_valid     (i_es_valid),
    .i_mem_ren      (i_mem_ren),
    .i_mem_wen      (i_mem_wen),
    .i_timer_done   (timer_done),
    .o_accept       (accept),
    .o_timer_start  (timer_start),
    .o_ram_en       (ram_en),
    .o_load_capture (load_capture),
    .o_ws_valid     (o_ws_valid),
    .o_busy         (o_ms_busy)
  );

  mem_wait_timer u_timer (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_start (timer_start),
    .o_done  (timer_done)
  );

  mem_stage_regs u_regs (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_accept       (accept),
    .i_load_capture (load_capture),
    .i_rd           (i_rd),
    .i_csr          (i_csr),
    .i_gpr_wen      (i_gpr_wen),
    .i_csr_wen      (i_csr_wen),
    .i_mem_ren      (i_mem_ren),
    .i_mem_wen      (i_mem_wen),
    .i_mem_op       (i_mem_op),
    .i_csr_inst_sel (i_csr_inst_sel),
    .i_rs2data      (i_rs2data),
    .i_csrrdata     (i_csrrdata),
    .i_alu_result   (i_alu_result),
    .i_csr_result   (i_csr_result),
    .i_ram_rdata    (ram_rdata),
    .o_rd           (o_rd),
    .o_csr          (o_csr),
    .o_gpr_wen      (o_gpr_wen),
    .o_csr_wen      (o_csr_wen),
    .o_mem_ren      (ms_mem_ren),
    .o_mem_wen      (ms_mem_wen),
    .o_mem_op       (ms_mem_op),
    .o_csr_inst_sel (ms_csr_inst_sel),
    .o_rs2data      (ms_rs2data),
    .o_csrrdata     (ms_csrrdata),
    .o_alu_result   (ms_alu_result),
    .o_csr_result   (o_csr_result), // csr result passes straight through
    .o_load_word    (load_word)
  );

  store_align u_store_align (
    .i_addr_lo (ms_alu_result[1:0]),
    .i_mem_op  (ms_mem_op),
    .i_rs2data (ms_rs2data),
    .o_byte_en (ram_byte_en),
    .o_wdata   (ram_wdata)
  );

  // word index only, upper address bits wrap
  data_ram u_ram (
    .i_clk     (i_clk),
    .i_en      (ram_en),
    .i_wen     (ms_mem_wen),
    .i_byte_en (ram_byte_en),
    .i_addr    (ms_alu_result[MEM_DEPTH_LOG2+1:2]),
    .i_wdata   (ram_wdata),
    .o_rdata   (ram_rdata)
  );

  load_result u_load_result (
    .i_addr_lo      (ms_alu_result[1:0]),
    .i_mem_op       (ms_mem_op),
    .i_mem_ren      (ms_mem_ren),
    .i_csr_inst_sel (ms_csr_inst_sel),
    .i_load_word    (load_word),
    .i_csrrdata     (ms_csrrdata),
    .i_alu_result   (ms_alu_result),
    .o_gpr_result   (o_gpr_result)
  );

endmodule

// ==== src/store_align.sv ====
// aligned stores only: SH ignores address bit 0, SW ignores bits 1:0
`timescale 1ns/1ps

module store_align (
  input  logic [1:0]                        i_addr_lo,
  input  rv_mem_pkg::mem_op_e               i_mem_op,
  input  logic [rv_mem_pkg::WORD_WD-1:0]    i_rs2data,
  output logic [rv_mem_pkg::BYTE_EN_WD-1:0] o_byte_en,
  output logic [rv_mem_pkg::WORD_WD-1:0]    o_wdata
);

  import rv_mem_pkg::*;

  always_comb begin
    unique case (i_mem_op)
      MEM_B, MEM_BU: begin
        o_byte_en = BYTE_EN_WD'(1) << i_addr_lo;
        o_wdata   = {4{i_rs2data[7:0]}}; // byte copied to every lane
      end
      MEM_H, MEM_HU: begin
        o_byte_en = i_addr_lo[1] ? 4'b1100 : 4'b0011;
        o_wdata   = {2{i_rs2data[15:0]}};
      end
      default: begin
        o_byte_en = '1; // SW
        o_wdata   = i_rs2data;
      end
    endcase
  end

endmodule

// ==== tb/mem_stage_checker.sv ====
// watches the DUT ports; assumes one instruction in flight and a RAM filled by stores before loads
`timescale 1ns/1ps

module mem_stage_checker (
  input logic                               i_clk,
  input logic                               i_reset,
  input logic                               i_es_valid,
  input logic [rv_mem_pkg::GPR_ADDR_WD-1:0] i_rd,
  input logic [rv_mem_pkg::CSR_ADDR_WD-1:0] i_csr,
  input logic                               i_gpr_wen,
  input logic                               i_csr_wen,
  input logic                               i_mem_ren,
  input logic                               i_mem_wen,
  input rv_mem_pkg::mem_op_e                i_mem_op,
  input logic                               i_csr_inst_sel,
  input logic [rv_mem_pkg::WORD_WD-1:0]     i_rs2data,
  input logic [rv_mem_pkg::WORD_WD-1:0]     i_csrrdata,
  input logic [rv_mem_pkg::WORD_WD-1:0]     i_alu_result,
  input logic [rv_mem_pkg::WORD_WD-1:0]     i_csr_result,
  input logic                               o_ws_valid,
  input logic                               o_gpr_wen,
  input logic [rv_mem_pkg::GPR_ADDR_WD-1:0] o_rd,
  input logic [rv_mem_pkg::WORD_WD-1:0]     o_gpr_result,
  input logic                               o_csr_wen,
  input logic [rv_mem_pkg::CSR_ADDR_WD-1:0] o_csr,
  input logic [rv_mem_pkg::WORD_WD-1:0]     o_csr_result,
  input logic                               o_ms_busy
);

  import rv_mem_pkg::*;

  localparam int BA_WD = MEM_DEPTH_LOG2 + 2; // byte address bits

  logic [7:0]             shadow [4*MEM_DEPTH];
  int                     error_count = 0;
  int                     checked_count = 0;
  logic                   pending = 1'b0;
  int                     wait_cycles;
  int                     exp_wait;
  logic                   exp_gpr_wen;
  logic                   exp_csr_wen;
  logic [GPR_ADDR_WD-1:0] exp_rd;
  logic [CSR_ADDR_WD-1:0] exp_csr;
  logic [WORD_WD-1:0]     exp_gpr_result;
  logic [WORD_WD-1:0]     exp_csr_result;

  function automatic int access_bytes(input mem_op_e op);
    return (op == MEM_W) ? 4 : (op inside {MEM_H, MEM_HU}) ? 2 : 1;
  endfunction

  // load data, else csr read data, else alu result
  function automatic logic [WORD_WD-1:0] expected_gpr(input logic ren, input mem_op_e op,
      input logic sel, input logic [WORD_WD-1:0] adr, input logic [WORD_WD-1:0] csrrdata,
      input logic [WORD_WD-1:0] alu);
    int                 n;
    int                 base;
    logic [WORD_WD-1:0] v;
    if (!ren) begin
      return sel ? csrrdata : alu;
    end
    n    = access_bytes(op);
    base = int'(adr) & (4 * MEM_DEPTH - n); // align down, wrap
    v    = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = shadow[BA_WD'(base + i)];
    end
    if (op == MEM_B) begin
      return {{24{v[7]}}, v[7:0]};
    end
    if (op == MEM_H) begin
      return {{16{v[15]}}, v[15:0]};
    end
    return v; // LW, LBU, LHU already zero filled
  endfunction

  task automatic shadow_store(input mem_op_e op, input logic [WORD_WD-1:0] adr,
                              input logic [WORD_WD-1:0] wdata);
    int n;
    int base;
    n    = access_bytes(op);
    base = int'(adr) & (4 * MEM_DEPTH - n);
    for (int i = 0; i < n; i++) begin
      shadow[BA_WD'(base + i)] = wdata[8*i +: 8];
    end
  endtask

  task automatic compare_field(input string name, input logic [WORD_WD-1:0] got,
                               input logic [WORD_WD-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
      error_count++;
    end
  endtask

  always @(posedge i_clk) begin
    if (!i_reset) begin
      if (pending) begin
        wait_cycles++;
      end
      if (o_ms_busy && !pending) begin
        $display("busy is high with no instruction accepted at %0t", $time);
        error_count++;
      end
      if (o_ws_valid && !pending) begin
        $display("writeback strobe with no instruction pending at %0t", $time);
        error_count++;
      end else if (o_ws_valid) begin
        if (wait_cycles != exp_wait) begin
          $display("writeback came %0d cycles after accept instead of %0d", wait_cycles, exp_wait);
          error_count++;
        end
        compare_field("o_gpr_wen", 32'(o_gpr_wen), 32'(exp_gpr_wen));
        compare_field("o_rd", 32'(o_rd), 32'(exp_rd));
        compare_field("o_gpr_result", o_gpr_result, exp_gpr_result);
        compare_field("o_csr_wen", 32'(o_csr_wen), 32'(exp_csr_wen));
        compare_field("o_csr", 32'(o_csr), 32'(exp_csr));
        compare_field("o_csr_result", o_csr_result, exp_csr_result);
        checked_count++;
        pending = 1'b0;
      end
      // strobes while busy are dropped by the DUT
      if (i_es_valid && !o_ms_busy) begin
        if (pending) begin
          $display("writeback strobe missing before the next accept at %0t", $time);
          error_count++;
        end
        pending        = 1'b1;
        wait_cycles    = 0;
        exp_wait       = (i_mem_ren || i_mem_wen) ? MEM_LATENCY + 1 : 1;
        exp_gpr_wen    = i_gpr_wen;
        exp_csr_wen    = i_csr_wen;
        exp_rd         = i_rd;
        exp_csr        = i_csr;
        exp_csr_result = i_csr_result;
        exp_gpr_result = expected_gpr(i_mem_ren, i_mem_op, i_csr_inst_sel, i_alu_result,
                                      i_csrrdata, i_alu_result);
        if (i_mem_wen) begin
          shadow_store(i_mem_op, i_alu_result, i_rs2data);
        end
      end
    end
  end

endmodule

// ==== tb/tb_rv_mem_stage.sv ====
// RAM is filled by word stores before any load since it has no reset; random fields use seed 44
`timescale 1ns/1ps

module tb_rv_mem_stage;

  import rv_mem_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int N_DIRECT   = 48; // bound on the directed cases
  localparam int N_RANDOM   = 300;
  localparam int N_OPS      = MEM_DEPTH + N_DIRECT + N_RANDOM;
  localparam int RUN_LIMIT  = N_OPS * (MEM_LATENCY + 3) * CLK_PERIOD + 200;

  logic                   i_clk = 1'b0;
  logic                   i_reset;
  logic                   i_es_valid;
  logic [GPR_ADDR_WD-1:0] i_rd;
  logic [CSR_ADDR_WD-1:0] i_csr;
  logic                   i_gpr_wen;
  logic                   i_csr_wen;
  logic                   i_mem_ren;
  logic                   i_mem_wen;
  mem_op_e                i_mem_op;
  logic                   i_csr_inst_sel;
  logic [WORD_WD-1:0]     i_rs2data;
  logic [WORD_WD-1:0]     i_csrrdata;
  logic [WORD_WD-1:0]     i_alu_result;
  logic [WORD_WD-1:0]     i_csr_result;
  logic                   o_ws_valid;
  logic                   o_gpr_wen;
  logic [GPR_ADDR_WD-1:0] o_rd;
  logic [WORD_WD-1:0]     o_gpr_result;
  logic                   o_csr_wen;
  logic [CSR_ADDR_WD-1:0] o_csr;
  logic [WORD_WD-1:0]     o_csr_result;
  logic                   o_ms_busy;

  int                     seed = 44;
  int                     ops_issued = 0;
  int                     total_errors;
  logic [WORD_WD-1:0]     addr;
  logic [WORD_WD-1:0]     r;

  rv_mem_stage dut0 (.*);
  mem_stage_checker chk0 (.*);

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  function automatic logic [WORD_WD-1:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic [WORD_WD-1:0] fill_word(input int w);
    return 32'(w + 1) * 32'h9e37_79b1; // differs for every word index
  endfunction

  function automatic mem_op_e pick_op(input logic [WORD_WD-1:0] rv, input logic store);
    case (store ? rv % 32'd3 : rv % 32'd5)
      0: return MEM_B;
      1: return MEM_H;
      2: return MEM_W;
      3: return MEM_BU;
      default: return MEM_HU;
    endcase
  endfunction

  // waits for the stage to go idle, strobes once, optionally strobes again while busy
  task automatic issue(input logic ren, input logic wen, input mem_op_e op,
                       input logic [WORD_WD-1:0] adr, input logic [WORD_WD-1:0] wdata,
                       input logic dup);
    @(posedge i_clk);
    while (o_ms_busy) @(posedge i_clk);
    i_es_valid     <= 1'b1;
    i_mem_ren      <= ren;
    i_mem_wen      <= wen;
    i_mem_op       <= op;
    i_alu_result   <= adr;
    i_rs2data      <= wdata;
    i_rd           <= GPR_ADDR_WD'(rand_word());
    i_csr          <= CSR_ADDR_WD'(rand_word());
    i_gpr_wen      <= 1'(rand_word());
    i_csr_wen      <= 1'(rand_word());
    i_csr_inst_sel <= 1'(rand_word());
    i_csrrdata     <= rand_word();
    i_csr_result   <= rand_word();
    ops_issued++;
    @(posedge i_clk); // accept edge
    if (dup) begin
      i_alu_result <= rand_word(); // must not be taken
      i_rs2data    <= rand_word();
      i_rd         <= GPR_ADDR_WD'(rand_word());
      @(posedge i_clk);
    end
    i_es_valid <= 1'b0;
  endtask

  initial begin
    #(RUN_LIMIT);
    $display("timeout after %0d ns, writeback never completed", RUN_LIMIT);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    i_reset        <= 1'b1;
    i_es_valid     <= 1'b0;
    i_rd           <= '0;
    i_csr          <= '0;
    i_gpr_wen      <= 1'b0;
    i_csr_wen      <= 1'b0;
    i_mem_ren      <= 1'b0;
    i_mem_wen      <= 1'b0;
    i_mem_op       <= MEM_W;
    i_csr_inst_sel <= 1'b0;
    i_rs2data      <= '0;
    i_csrrdata     <= '0;
    i_alu_result   <= '0;
    i_csr_result   <= '0;
    repeat (3) @(posedge i_clk);
    i_reset <= 1'b0;
    repeat (4) @(posedge i_clk); // idle, checker expects quiet outputs
    for (int w = 0; w < MEM_DEPTH; w++) begin
      issue(1'b0, 1'b1, MEM_W, 32'(4 * w), fill_word(w), 1'b0);
    end
    // non-memory pass-through
    for (int k = 0; k < 6; k++) begin
      issue(1'b0, 1'b0, MEM_W, rand_word(), rand_word(), k[0]);
    end
    for (int k = 0; k < 4; k++) begin
      addr = rand_word() & 32'h3fc;
      issue(1'b0, 1'b1, MEM_W, addr, rand_word(), 1'b0);
      issue(1'b1, 1'b0, MEM_W, addr, '0, 1'b1);
    end
    // byte and halfword lanes, each followed by a word read
    addr = 32'h0000_0120;
    for (int lane = 0; lane < 4; lane++) begin
      issue(1'b0, 1'b1, MEM_B, addr + 32'(lane), rand_word(), 1'b0);
      issue(1'b1, 1'b0, MEM_W, addr, '0, 1'b0);
    end
    for (int lane = 1; lane < 4; lane += 2) begin
      issue(1'b0, 1'b1, MEM_H, addr + 32'h4 + 32'(lane), rand_word(), 1'b0); // odd address
      issue(1'b1, 1'b0, MEM_W, addr + 32'h4, '0, 1'b0);
    end
    addr = 32'h0000_0200;
    issue(1'b0, 1'b1, MEM_W, addr, 32'h9c8b_f2a7, 1'b0); // top bit set in every byte
    for (int lane = 0; lane < 4; lane++) begin
      issue(1'b1, 1'b0, MEM_B, addr + 32'(lane), '0, 1'b0);
      issue(1'b1, 1'b0, MEM_BU, addr + 32'(lane), '0, 1'b0);
      if (lane[0] == 1'b0) begin
        issue(1'b1, 1'b0, MEM_H, addr + 32'(lane), '0, 1'b0);
        issue(1'b1, 1'b0, MEM_HU, addr + 32'(lane), '0, 1'b0);
      end
    end
    for (int k = 0; k < N_RANDOM; k++) begin
      r    = rand_word();
      addr = rand_word() & 32'(4 * MEM_DEPTH - 1);
      case (r % 32'd3)
        0: issue(1'b0, 1'b0, pick_op(rand_word(), 1'b0), rand_word(), rand_word(), r[8]);
        1: issue(1'b1, 1'b0, pick_op(rand_word(), 1'b0), addr, rand_word(), r[8]);
        default: issue(1'b0, 1'b1, pick_op(rand_word(), 1'b1), addr, rand_word(), r[8]);
      endcase
    end
    @(posedge i_clk);
    while (o_ms_busy) @(posedge i_clk);
    repeat (2) @(posedge i_clk);
    total_errors = chk0.error_count;
    if (chk0.checked_count != ops_issued) begin
      $display("only %0d of %0d instructions reached writeback", chk0.checked_count, ops_issued);
      total_errors++;
    end
    $display("errors: %0d, writebacks checked: %0d", total_errors, chk0.checked_count);
    if (total_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
